// File: verilog/rf_defs.svh
/*
 * Register file widths and counts
 * Shared by the package and the RTL
 */

`ifndef RF_DEFS_SVH
`define RF_DEFS_SVH

// Data bits per register word
`define RF_DATA_W   32

// Integrity bits per register word
`define RF_INTG_W   7

// Register index width and register count
`define RF_ADDR_W   5
`define RF_NUM_REGS 32

`endif

// File: verilog/rf_pkg.sv
/*
 * Register file package
 * Word and address types and the interleaved integrity code
 */

`include "rf_defs.svh"

package rf_pkg;

  typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

  // Data in the upper bits, integrity below
  typedef struct packed {
    logic [`RF_DATA_W-1:0] data;
    logic [`RF_INTG_W-1:0] intg;
  } rf_word_t;

  // Check bit k covers every data bit whose index mod 7 is k
  function automatic logic [`RF_INTG_W-1:0] rf_intg_calc(input logic [`RF_DATA_W-1:0] data);
    logic [`RF_INTG_W-1:0] intg;
    intg = '0;
    for (int i = 0; i < `RF_DATA_W; i++) begin
      intg[i % `RF_INTG_W] = intg[i % `RF_INTG_W] ^ data[i];
    end
    return intg;
  endfunction

endpackage

// File: verilog/rf_read_if.sv
/*
 * Register file read port interface
 * One port's accepted request and the storage lookup behind it
 */
`timescale 1ns/100ps

interface rf_read_if import rf_pkg::*; ();

  // Request as accepted by the port
  logic     req;
  rf_addr_t addr;

  // Combinational lookup from the array
  rf_word_t rword;

  modport storage (
    input  req,
    input  addr,
    output rword
  );

  modport port (
    output req,
    output addr,
    input  rword
  );

endinterface

// File: verilog/rf_write_check.sv
/*
 * Register file write check
 * Recomputes write integrity, drops bad writes with a bus alert
 * and registers good ones towards the array
 */
`timescale 1ns/100ps

`include "rf_defs.svh"

module rf_write_check import rf_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clk_en_i,

  input  logic                  we_i,
  input  rf_addr_t              waddr_i,
  input  logic [`RF_DATA_W-1:0] wdata_i,
  input  logic [`RF_INTG_W-1:0] wdata_intg_i,

  output logic                  wr_en_o,
  output rf_addr_t              wr_addr_o,
  output rf_word_t              wr_word_o,

  output logic                  alert_bus_o
);

  logic [`RF_INTG_W-1:0] intg_calc;
  logic                  intg_ok;
  logic                  wr_take;
  logic                  wr_good;
  logic                  wr_bad;

  assign intg_calc = rf_intg_calc(wdata_i);
  assign intg_ok   = (intg_calc == wdata_intg_i);

  // Writes only count while awake
  assign wr_take = clk_en_i & we_i;
  assign wr_good = wr_take & intg_ok;
  assign wr_bad  = wr_take & ~intg_ok;

  ////////////////////////////////////////
  // Write strobe and alert
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_en_o     <= 1'b0;
      alert_bus_o <= 1'b0;
    end else begin
      wr_en_o     <= wr_good;
      alert_bus_o <= wr_bad;
    end
  end

  ////////////////////////////////////////
  // Write payload
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_good) begin
      wr_addr_o      <= waddr_i;
      wr_word_o.data <= wdata_i;
      wr_word_o.intg <= wdata_intg_i;
    end
  end

endmodule

// File: verilog/rf_storage.sv
/*
 * Register file array
 * 31 stored words plus a hardwired zero register 0,
 * one write port and two combinational read lookups
 */
`timescale 1ns/100ps

`include "rf_defs.svh"

module rf_storage import rf_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       wr_en_i,
  input  rf_addr_t   wr_addr_i,
  input  rf_word_t   wr_word_i,

  rf_read_if.storage rd_a,
  rf_read_if.storage rd_b
);

  // Register 0 has no storage
  rf_word_t regs_q [1:`RF_NUM_REGS-1];

  logic     wr_valid;

  assign wr_valid = wr_en_i & (wr_addr_i != '0);

  ////////////////////////////////////////
  // Write
  ////////////////////////////////////////

  // Zero word carries valid integrity
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `RF_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_valid) begin
      regs_q[wr_addr_i] <= wr_word_i;
    end
  end

  ////////////////////////////////////////
  // Read lookups
  ////////////////////////////////////////

  function automatic rf_word_t rd_lookup(input logic req, input rf_addr_t addr);
    rf_word_t word;
    word = '0;
    // Register 0 and idle ports read as the zero word
    if (req && (addr != '0)) begin
      word = regs_q[addr];
    end
    return word;
  endfunction

  always_comb begin
    rd_a.rword = rd_lookup(rd_a.req, rd_a.addr);
  end

  always_comb begin
    rd_b.rword = rd_lookup(rd_b.req, rd_b.addr);
  end

endmodule

// File: verilog/rf_read_port.sv
/*
 * Register file read port
 * Accepts a request while awake and returns data and integrity
 * with rvalid in the following cycle
 */
`timescale 1ns/100ps

`include "rf_defs.svh"

module rf_read_port import rf_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clk_en_i,

  input  logic                  req_i,
  input  rf_addr_t              addr_i,

  rf_read_if.port               rd,

  output logic                  rvalid_o,
  output logic [`RF_DATA_W-1:0] rdata_o,
  output logic [`RF_INTG_W-1:0] rdata_intg_o
);

  logic req_take;

  // Requests during sleep are dropped
  assign req_take = req_i & clk_en_i;

  assign rd.req  = req_take;
  assign rd.addr = addr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_take;
    end
  end

  // Response word, held until the next accepted request
  always_ff @(posedge clk_i) begin
    if (req_take) begin
      rdata_o      <= rd.rword.data;
      rdata_intg_o <= rd.rword.intg;
    end
  end

endmodule

// File: verilog/rf_sleep_ctrl.sv
/*
 * Register file wake and sleep control
 * Builds the enable from the registered busy flag and wake inputs
 */
`timescale 1ns/100ps

module rf_sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,

  input  logic busy_i,
  input  logic irq_pending_i,
  input  logic debug_req_i,
  input  logic irq_nm_i,

  output logic clk_en_o,
  output logic core_sleep_o
);

  logic busy_q;
  logic clk_en;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= busy_i;
    end
  end

  // Any wake source keeps the block running
  assign clk_en = busy_q | irq_pending_i | debug_req_i | irq_nm_i;

  assign clk_en_o     = clk_en;
  assign core_sleep_o = ~clk_en;

endmodule

// File: verilog/rf_top.sv
/*
 * Register file subsystem top level
 * Integrity checked write port, 32 word array, two read ports
 * and sleep control
 */
`timescale 1ns/100ps

`include "rf_defs.svh"

module rf_top import rf_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // Wake and sleep
  input  logic                  busy_i,
  input  logic                  irq_pending_i,
  input  logic                  debug_req_i,
  input  logic                  irq_nm_i,
  output logic                  core_sleep_o,

  // Write port
  input  logic                  we_i,
  input  logic [`RF_ADDR_W-1:0] waddr_i,
  input  logic [`RF_DATA_W-1:0] wdata_i,
  input  logic [`RF_INTG_W-1:0] wdata_intg_i,

  // Read port A
  input  logic                  ra_req_i,
  input  logic [`RF_ADDR_W-1:0] ra_addr_i,
  output logic                  ra_rvalid_o,
  output logic [`RF_DATA_W-1:0] ra_rdata_o,
  output logic [`RF_INTG_W-1:0] ra_rdata_intg_o,

  // Read port B
  input  logic                  rb_req_i,
  input  logic [`RF_ADDR_W-1:0] rb_addr_i,
  output logic                  rb_rvalid_o,
  output logic [`RF_DATA_W-1:0] rb_rdata_o,
  output logic [`RF_INTG_W-1:0] rb_rdata_intg_o,

  output logic                  alert_major_bus_o
);

  logic     clk_en;

  logic     wr_en;
  rf_addr_t wr_addr;
  rf_word_t wr_word;

  rf_read_if rd_a ();
  rf_read_if rd_b ();

  ////////////////////////////////////////
  // Sleep control
  ////////////////////////////////////////

  rf_sleep_ctrl u_sleep_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .busy_i       (busy_i),
    .irq_pending_i(irq_pending_i),
    .debug_req_i  (debug_req_i),
    .irq_nm_i     (irq_nm_i),
    .clk_en_o     (clk_en),
    .core_sleep_o (core_sleep_o)
  );

  ////////////////////////////////////////
  // Write path
  ////////////////////////////////////////

  rf_write_check u_write_check (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clk_en_i    (clk_en),
    .we_i        (we_i),
    .waddr_i     (waddr_i),
    .wdata_i     (wdata_i),
    .wdata_intg_i(wdata_intg_i),
    .wr_en_o     (wr_en),
    .wr_addr_o   (wr_addr),
    .wr_word_o   (wr_word),
    .alert_bus_o (alert_major_bus_o)
  );

  rf_storage u_storage (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wr_en_i  (wr_en),
    .wr_addr_i(wr_addr),
    .wr_word_i(wr_word),
    .rd_a     (rd_a.storage),
    .rd_b     (rd_b.storage)
  );

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////

  rf_read_port u_port_a (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clk_en_i    (clk_en),
    .req_i       (ra_req_i),
    .addr_i      (ra_addr_i),
    .rd          (rd_a.port),
    .rvalid_o    (ra_rvalid_o),
    .rdata_o     (ra_rdata_o),
    .rdata_intg_o(ra_rdata_intg_o)
  );

  rf_read_port u_port_b (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clk_en_i    (clk_en),
    .req_i       (rb_req_i),
    .addr_i      (rb_addr_i),
    .rd          (rd_b.port),
    .rvalid_o    (rb_rvalid_o),
    .rdata_o     (rb_rdata_o),
    .rdata_intg_o(rb_rdata_intg_o)
  );

endmodule

// File: test/rf_sva.sv
/*
 * Register file protocol assertions
 * Bound to the top level for rvalid timing, alert width and sleep
 */
`timescale 1ns/100ps

module rf_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic busy_i,
  input logic irq_pending_i,
  input logic debug_req_i,
  input logic irq_nm_i,
  input logic core_sleep_i,
  input logic ra_req_i,
  input logic rb_req_i,
  input logic ra_rvalid_i,
  input logic rb_rvalid_i,
  input logic alert_i
);

  // Count of failed assertions
  int fail_count = 0;

  // Response exactly one cycle after an accepted request
  rvalid_a_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |-> ra_rvalid_i == $past(ra_req_i && !core_sleep_i))
    else begin
      $error("Port A rvalid does not follow an accepted request");
      fail_count++;
    end

  rvalid_b_timing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |-> rb_rvalid_i == $past(rb_req_i && !core_sleep_i))
    else begin
      $error("Port B rvalid does not follow an accepted request");
      fail_count++;
    end

  alert_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_i |=> !alert_i)
    else begin
      $error("Bus alert held for more than one cycle");
      fail_count++;
    end

  // Registered busy flag is the previous busy_i
  sleep_from_wake: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(rst_ni) |->
      core_sleep_i == !($past(busy_i) || irq_pending_i || debug_req_i || irq_nm_i))
    else begin
      $error("core_sleep_o does not match the wake sources");
      fail_count++;
    end

endmodule

// File: test/rf_tb.sv
/*
 * Register file subsystem testbench
 * Random writes and reads against a shadow model, bad integrity and sleep
 */
`timescale 1ns/100ps

`include "rf_defs.svh"

module rf_tb;

  localparam int CLK_PERIOD = 8;
  localparam int N_OPS      = 32;
  localparam int WORD_W     = `RF_DATA_W + `RF_INTG_W;
  // Per-test cycle counts summed, with headroom
  localparam int TEST_CYCLES = 6 * N_OPS + 60;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  typedef logic [WORD_W-1:0] word_t;

  logic                  clk;
  logic                  rst_n;
  logic                  busy;
  logic                  irq_pending;
  logic                  debug_req;
  logic                  irq_nm;
  logic                  core_sleep;
  logic                  we;
  logic [`RF_ADDR_W-1:0] waddr;
  logic [`RF_DATA_W-1:0] wdata;
  logic [`RF_INTG_W-1:0] wdata_intg;
  logic                  ra_req;
  logic [`RF_ADDR_W-1:0] ra_addr;
  logic                  ra_rvalid;
  logic [`RF_DATA_W-1:0] ra_rdata;
  logic [`RF_INTG_W-1:0] ra_rdata_intg;
  logic                  rb_req;
  logic [`RF_ADDR_W-1:0] rb_addr;
  logic                  rb_rvalid;
  logic [`RF_DATA_W-1:0] rb_rdata;
  logic [`RF_INTG_W-1:0] rb_rdata_intg;
  logic                  alert;

  word_t       shadow [`RF_NUM_REGS];
  word_t       exp_a [$];
  word_t       exp_b [$];
  logic [31:0] lfsr_state;
  logic        busy_model;
  int          errors;
  int          checks;
  int          test_num;
  int          err_mark;
  int          sva_mark;

  rf_top UUT (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .busy_i           (busy),
    .irq_pending_i    (irq_pending),
    .debug_req_i      (debug_req),
    .irq_nm_i         (irq_nm),
    .core_sleep_o     (core_sleep),
    .we_i             (we),
    .waddr_i          (waddr),
    .wdata_i          (wdata),
    .wdata_intg_i     (wdata_intg),
    .ra_req_i         (ra_req),
    .ra_addr_i        (ra_addr),
    .ra_rvalid_o      (ra_rvalid),
    .ra_rdata_o       (ra_rdata),
    .ra_rdata_intg_o  (ra_rdata_intg),
    .rb_req_i         (rb_req),
    .rb_addr_i        (rb_addr),
    .rb_rvalid_o      (rb_rvalid),
    .rb_rdata_o       (rb_rdata),
    .rb_rdata_intg_o  (rb_rdata_intg),
    .alert_major_bus_o(alert)
  );

  bind rf_top rf_sva u_sva (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .busy_i       (busy_i),
    .irq_pending_i(irq_pending_i),
    .debug_req_i  (debug_req_i),
    .irq_nm_i     (irq_nm_i),
    .core_sleep_i (core_sleep_o),
    .ra_req_i     (ra_req_i),
    .rb_req_i     (rb_req_i),
    .ra_rvalid_i  (ra_rvalid_o),
    .rb_rvalid_i  (rb_rvalid_o),
    .alert_i      (alert_major_bus_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic logic [`RF_ADDR_W-1:0] rand_addr();
    logic [31:0] value;
    value = rand_bits(`RF_ADDR_W);
    return value[`RF_ADDR_W-1:0];
  endfunction

  // Check bit k is the XOR of data bits k, k+7, k+14, ...
  function automatic logic [`RF_INTG_W-1:0] intg_ref(input logic [`RF_DATA_W-1:0] data);
    logic [`RF_INTG_W-1:0] intg;
    intg = '0;
    for (int k = 0; k < `RF_INTG_W; k++) begin
      for (int i = k; i < `RF_DATA_W; i += `RF_INTG_W) begin
        intg[k] = intg[k] ^ data[i];
      end
    end
    return intg;
  endfunction

  function automatic word_t rf_expected(input logic [`RF_ADDR_W-1:0] addr);
    return (addr == '0) ? '0 : shadow[addr];
  endfunction

  function automatic logic awake_ref();
    return busy_model | irq_pending | debug_req | irq_nm;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_model <= 1'b0;
    end else begin
      busy_model <= busy;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic compare_word(input string port, input logic [`RF_DATA_W-1:0] data,
                              input logic [`RF_INTG_W-1:0] intg, input word_t exp);
    checks += 2;
    assert (data == exp[WORD_W-1:`RF_INTG_W]) else begin
      $display("Error: %s_rdata_o = %h, expected %h", port, data, exp[WORD_W-1:`RF_INTG_W]);
      errors++;
    end
    assert (intg == exp[`RF_INTG_W-1:0]) else begin
      $display("Error: %s_rdata_intg_o = %h, expected %h", port, intg, exp[`RF_INTG_W-1:0]);
      errors++;
    end
  endtask

  task automatic check_alert(input logic exp);
    checks++;
    assert (alert == exp) else begin
      $display("Error: alert_major_bus_o = %h, expected %h", alert, exp);
      errors++;
    end
  endtask

  task automatic check_sleep();
    #1;
    checks++;
    assert (core_sleep == !awake_ref()) else begin
      $display("Error: core_sleep_o = %h, expected %h", core_sleep, !awake_ref());
      errors++;
    end
  endtask

  // Responses are compared where outputs are stable
  always @(negedge clk) begin
    if (rst_n) begin
      if (ra_rvalid) begin
        checks++;
        assert (exp_a.size() > 0) else begin
          $display("Port A returned rvalid without an accepted request");
          errors++;
        end
        if (exp_a.size() > 0) compare_word("ra", ra_rdata, ra_rdata_intg, exp_a.pop_front());
      end
      if (rb_rvalid) begin
        checks++;
        assert (exp_b.size() > 0) else begin
          $display("Port B returned rvalid without an accepted request");
          errors++;
        end
        if (exp_b.size() > 0) compare_word("rb", rb_rdata, rb_rdata_intg, exp_b.pop_front());
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  task automatic write_word(input logic [`RF_ADDR_W-1:0] addr,
                            input logic [`RF_DATA_W-1:0] data, input logic flip, input int bit_idx);
    logic [`RF_INTG_W-1:0] intg;
    logic                  awake;
    intg  = intg_ref(data);
    awake = awake_ref();
    if (flip) intg[bit_idx] = ~intg[bit_idx];
    we         = 1'b1;
    waddr      = addr;
    wdata      = data;
    wdata_intg = intg;
    if (awake && !flip && addr != '0) shadow[addr] = {data, intg};
    @(negedge clk);
    we = 1'b0;
    check_alert(awake && flip);
    // Idle cycle so a following read sees the new value
    @(negedge clk);
    check_alert(1'b0);
  endtask

  task automatic read_pair(input logic [`RF_ADDR_W-1:0] addr_a,
                           input logic [`RF_ADDR_W-1:0] addr_b);
    ra_req  = 1'b1;
    ra_addr = addr_a;
    rb_req  = 1'b1;
    rb_addr = addr_b;
    if (awake_ref()) begin
      exp_a.push_back(rf_expected(addr_a));
      exp_b.push_back(rf_expected(addr_b));
    end
    @(negedge clk);
    ra_req = 1'b0;
    rb_req = 1'b0;
  endtask

  task automatic drain();
    repeat (2) @(negedge clk);
    checks++;
    assert (exp_a.size() == 0 && exp_b.size() == 0) else begin
      $display("Read responses missing: %0d on port A, %0d on port B",
               exp_a.size(), exp_b.size());
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    errors  += UUT.u_sva.fail_count - sva_mark;
    sva_mark = UUT.u_sva.fail_count;
    test_num++;
    $display("Test %0d %s: %0d errors", test_num, name, errors - err_mark);
    err_mark = errors;
  endtask

  initial begin
    #((TEST_CYCLES + 4) * CLK_PERIOD + 200);
    $display("Timeout: the run did not finish within the watchdog limit");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    logic [`RF_ADDR_W-1:0] addr;
    int                    bit_idx;
    clk         = 1'b0;
    rst_n       = 1'b0;
    busy        = 1'b0;
    irq_pending = 1'b1;
    debug_req   = 1'b0;
    irq_nm      = 1'b0;
    we          = 1'b0;
    waddr       = '0;
    wdata       = '0;
    wdata_intg  = '0;
    ra_req      = 1'b0;
    ra_addr     = '0;
    rb_req      = 1'b0;
    rb_addr     = '0;
    errors      = 0;
    checks      = 0;
    test_num    = 0;
    err_mark    = 0;
    sva_mark    = 0;
    lfsr_state  = 32'h3d;
    for (int i = 0; i < `RF_NUM_REGS; i++) shadow[i] = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < N_OPS; i++) read_pair(rand_addr(), rand_addr());
    write_word('0, rand_bits(32), 1'b0, 0);
    read_pair('0, '0);
    drain();
    end_test("reset and register 0");

    for (int i = 0; i < N_OPS; i++) begin
      addr = rand_addr();
      write_word(addr, rand_bits(32), 1'b0, 0);
      read_pair(addr, rand_addr());
    end
    drain();
    end_test("write then read");

    for (int i = 0; i < N_OPS; i++) begin
      addr = rand_addr();
      read_pair(addr, addr ^ 5'h1);
    end
    drain();
    end_test("back-to-back reads");

    for (int i = 0; i < 4; i++) begin
      addr    = rand_addr() | 5'h1;
      bit_idx = int'(rand_bits(3)) % `RF_INTG_W;
      write_word(addr, rand_bits(32), 1'b1, bit_idx);
      read_pair(addr, addr);
    end
    drain();
    end_test("bad integrity");

    // All wake sources low
    irq_pending = 1'b0;
    check_sleep();
    addr = rand_addr() | 5'h1;
    write_word(addr, rand_bits(32), 1'b0, 0);
    write_word(addr, rand_bits(32), 1'b1, 2);
    read_pair(addr, addr);
    irq_nm = 1'b1;
    check_sleep();
    read_pair(addr, addr);
    irq_nm    = 1'b0;
    debug_req = 1'b1;
    check_sleep();
    debug_req = 1'b0;
    busy      = 1'b1;
    check_sleep();
    @(negedge clk);
    check_sleep();
    read_pair(addr, '0);
    busy = 1'b0;
    check_sleep();
    @(negedge clk);
    check_sleep();
    drain();
    end_test("sleep");

    $display("Tests %0d, checks %0d, errors %0d", test_num, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: rf_subsys.f
+incdir+verilog
verilog/rf_pkg.sv
verilog/rf_read_if.sv
verilog/rf_write_check.sv
verilog/rf_storage.sv
verilog/rf_read_port.sv
verilog/rf_sleep_ctrl.sv
verilog/rf_top.sv
test/rf_sva.sv
test/rf_tb.sv
